/* build.f */
+incdir+source
source/cache_types.sv
source/hit_miss.sv
source/plru_tree.sv
source/cache_arrays.sv
source/cache_control.sv
source/cache.sv
tb/cache_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    -f build.f --top-module cache_tb --Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/cache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Only the pass line counts as success
if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi
exit 1

/* source/cache.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cpu_read,
    input  logic                        cpu_write,
    input  cache_types::cache_addr_u    cpu_addr,
    input  logic [`CACHE_WORD_W-1:0]    cpu_wdata,
    input  logic [`CACHE_WORD_W/8-1:0]  cpu_byte_en,
    output logic                        cpu_resp,
    output logic [`CACHE_WORD_W-1:0]    cpu_rdata,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [`CACHE_ADDR_W-1:0]    mem_addr,
    output logic [`CACHE_LINE_W-1:0]    mem_wdata,
    input  logic [`CACHE_LINE_W-1:0]    mem_rdata,
    input  logic                        mem_resp
);

    cache_types::tag_entry_t   entry_a;
    cache_types::tag_entry_t   entry_b;
    cache_types::tag_entry_t   entry_c;
    cache_types::tag_entry_t   entry_d;
    logic                      valid_a;
    logic                      valid_b;
    logic                      valid_c;
    logic                      valid_d;
    cache_types::hit_miss_e    result;
    cache_types::way_e         way_visit;
    cache_types::way_e         way_replace;
    cache_types::way_e         way_sel;
    logic [`CACHE_LINE_W-1:0]  line_out;
    logic [`CACHE_TAG_W-1:0]   victim_tag;
    cache_types::tag_entry_t   tag_in;
    logic                      tag_write;
    logic                      set_dirty;
    logic                      word_write;
    logic                      line_fill;
    logic                      plru_update;

    // Tag of the way being visited, used for write-back
    always_comb begin
        case (way_visit)
            cache_types::way_a: victim_tag = entry_a.tag;
            cache_types::way_b: victim_tag = entry_b.tag;
            cache_types::way_c: victim_tag = entry_c.tag;
            default:            victim_tag = entry_d.tag;
        endcase
    end

    hit_miss i_hit_miss (
        .entry_a     (entry_a),
        .entry_b     (entry_b),
        .entry_c     (entry_c),
        .entry_d     (entry_d),
        .valid_a     (valid_a),
        .valid_b     (valid_b),
        .valid_c     (valid_c),
        .valid_d     (valid_d),
        .curr_tag    (cpu_addr.f.tag),
        .way_replace (way_replace),
        .result      (result),
        .way_visit   (way_visit)
    );

    plru_tree i_plru_tree (
        .clk         (clk),
        .rst_n       (rst_n),
        .set_index   (cpu_addr.f.index),
        .plru_update (plru_update),
        .way_visit   (way_visit),
        .way_replace (way_replace)
    );

    cache_arrays i_cache_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .set_index  (cpu_addr.f.index),
        .way_sel    (way_sel),
        .tag_write  (tag_write),
        .tag_in     (tag_in),
        .set_dirty  (set_dirty),
        .word_write (word_write),
        .word_sel   (cpu_addr.f.word),
        .word_data  (cpu_wdata),
        .byte_en    (cpu_byte_en),
        .line_fill  (line_fill),
        .fill_data  (mem_rdata),
        .entry_a    (entry_a),
        .entry_b    (entry_b),
        .entry_c    (entry_c),
        .entry_d    (entry_d),
        .valid_a    (valid_a),
        .valid_b    (valid_b),
        .valid_c    (valid_c),
        .valid_d    (valid_d),
        .line_out   (line_out)
    );

    cache_control i_cache_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_read    (cpu_read),
        .cpu_write   (cpu_write),
        .cpu_addr    (cpu_addr),
        .result      (result),
        .way_visit   (way_visit),
        .line_out    (line_out),
        .victim_tag  (victim_tag),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp),
        .cpu_resp    (cpu_resp),
        .cpu_rdata   (cpu_rdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .way_sel     (way_sel),
        .tag_write   (tag_write),
        .tag_in      (tag_in),
        .set_dirty   (set_dirty),
        .word_write  (word_write),
        .line_fill   (line_fill),
        .plru_update (plru_update)
    );

endmodule

`default_nettype wire

/* source/cache_arrays.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_arrays (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`CACHE_IDX_W-1:0]     set_index,
    input  cache_types::way_e           way_sel,
    input  logic                        tag_write,
    input  cache_types::tag_entry_t     tag_in,
    input  logic                        set_dirty,
    input  logic                        word_write,
    input  logic [`CACHE_OFS_W-3:0]     word_sel,
    input  logic [`CACHE_WORD_W-1:0]    word_data,
    input  logic [`CACHE_WORD_W/8-1:0]  byte_en,
    input  logic                        line_fill,
    input  logic [`CACHE_LINE_W-1:0]    fill_data,
    output cache_types::tag_entry_t     entry_a,
    output cache_types::tag_entry_t     entry_b,
    output cache_types::tag_entry_t     entry_c,
    output cache_types::tag_entry_t     entry_d,
    output logic                        valid_a,
    output logic                        valid_b,
    output logic                        valid_c,
    output logic                        valid_d,
    output logic [`CACHE_LINE_W-1:0]    line_out
);

    // Status bits, way by set
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_q;

    logic [`CACHE_TAG_W-1:0]  tag_q  [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_LINE_W-1:0] data_q [`CACHE_WAYS][`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            // New tag always lands valid
            if (tag_write) begin
                valid_q[way_sel][set_index] <= 1'b1;
                dirty_q[way_sel][set_index] <= tag_in.dirty;
            end
            if (set_dirty) begin
                dirty_q[way_sel][set_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_write) begin
            tag_q[way_sel][set_index] <= tag_in.tag;
        end
        if (line_fill) begin
            data_q[way_sel][set_index] <= fill_data;
        end else if (word_write) begin
            // Merge only enabled bytes
            for (int b = 0; b < `CACHE_WORD_W / 8; b++) begin
                if (byte_en[b]) begin
                    data_q[way_sel][set_index][word_sel * `CACHE_WORD_W + b * 8 +: 8]
                        <= word_data[b * 8 +: 8];
                end
            end
        end
    end

    // Addressed set, read out combinationally
    assign entry_a = {dirty_q[0][set_index], tag_q[0][set_index]};
    assign entry_b = {dirty_q[1][set_index], tag_q[1][set_index]};
    assign entry_c = {dirty_q[2][set_index], tag_q[2][set_index]};
    assign entry_d = {dirty_q[3][set_index], tag_q[3][set_index]};

    assign valid_a = valid_q[0][set_index];
    assign valid_b = valid_q[1][set_index];
    assign valid_c = valid_q[2][set_index];
    assign valid_d = valid_q[3][set_index];

    assign line_out = data_q[way_sel][set_index];

endmodule

`default_nettype wire

/* source/cache_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cpu_read,
    input  logic                        cpu_write,
    input  cache_types::cache_addr_u    cpu_addr,
    input  cache_types::hit_miss_e      result,
    input  cache_types::way_e           way_visit,
    input  logic [`CACHE_LINE_W-1:0]    line_out,
    input  logic [`CACHE_TAG_W-1:0]     victim_tag,
    input  logic [`CACHE_LINE_W-1:0]    mem_rdata,
    input  logic                        mem_resp,
    output logic                        cpu_resp,
    output logic [`CACHE_WORD_W-1:0]    cpu_rdata,
    output logic                        mem_read,
    output logic                        mem_write,
    output logic [`CACHE_ADDR_W-1:0]    mem_addr,
    output logic [`CACHE_LINE_W-1:0]    mem_wdata,
    output cache_types::way_e           way_sel,
    output logic                        tag_write,
    output cache_types::tag_entry_t     tag_in,
    output logic                        set_dirty,
    output logic                        word_write,
    output logic                        line_fill,
    output logic                        plru_update
);

    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_compare    = 2'd1;
    localparam logic [1:0] st_write_back = 2'd2;
    localparam logic [1:0] st_allocate   = 2'd3;

    logic [1:0]               state;
    logic [1:0]               state_next;
    logic                     is_hit;
    cache_types::way_e        miss_way;
    cache_types::cache_addr_u line_addr;

    assign is_hit = (result == cache_types::hit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Victim way held across write-back and allocate
    always_ff @(posedge clk) begin
        if (state == st_compare && !is_hit) begin
            miss_way <= way_visit;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (cpu_read || cpu_write) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (is_hit) begin
                    state_next = st_idle;
                end else if (result == cache_types::dirty_miss) begin
                    state_next = st_write_back;
                end else begin
                    state_next = st_allocate;
                end
            end
            st_write_back: begin
                if (mem_resp) begin
                    state_next = st_allocate;
                end
            end
            default: begin
                // Refill done, retry the lookup
                if (mem_resp) begin
                    state_next = st_compare;
                end
            end
        endcase
    end

    // Lookup result drives arrays until a miss is latched
    assign way_sel = (state == st_idle || state == st_compare) ? way_visit : miss_way;

    // Hit answers in the compare cycle
    assign cpu_resp    = (state == st_compare) && is_hit;
    assign cpu_rdata   = line_out[cpu_addr.f.word * `CACHE_WORD_W +: `CACHE_WORD_W];
    assign plru_update = cpu_resp;
    assign word_write  = cpu_resp && cpu_write;
    assign set_dirty   = word_write;

    // Memory requests held as levels until mem_resp
    assign mem_write = (state == st_write_back);
    assign mem_read  = (state == st_allocate);
    assign mem_wdata = line_out;
    assign line_fill = mem_read && mem_resp;
    assign tag_write = line_fill;

    // Fill lands clean, a write hit dirties it afterwards
    always_comb begin
        tag_in.dirty = 1'b0;
        tag_in.tag   = cpu_addr.f.tag;
    end

    // Line-aligned address, victim tag while writing back
    always_comb begin
        line_addr.raw     = '0;
        line_addr.f.index = cpu_addr.f.index;
        line_addr.f.tag   = mem_write ? victim_tag : cpu_addr.f.tag;
    end

    assign mem_addr = line_addr.raw;

endmodule

`default_nettype wire

/* source/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Address split: tag | index | word | byte
`define CACHE_ADDR_W 32
`define CACHE_TAG_W  23
`define CACHE_IDX_W  4
`define CACHE_OFS_W  5

// Geometry
`define CACHE_SETS   16
`define CACHE_WAYS   4

// Line is 8 words of 32 bits
`define CACHE_LINE_W 256
`define CACHE_WORD_W 32

`endif

/* source/cache_types.sv */
`default_nettype none

`include "cache_defines.svh"

package cache_types;

    // Lookup view of an address
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]   tag;
        logic [`CACHE_IDX_W-1:0]   index;
        logic [`CACHE_OFS_W-3:0]   word;
        logic [1:0]                byte_ofs;
    } addr_fields_t;

    // Raw for the memory port, fields for lookup
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0]  raw;
        addr_fields_t              f;
    } cache_addr_u;

    // Dirty bit on top of the tag, 24 bits
    typedef struct packed {
        logic                      dirty;
        logic [`CACHE_TAG_W-1:0]   tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        hit,
        clean_miss,
        dirty_miss
    } hit_miss_e;

    typedef enum logic [1:0] {
        way_a,
        way_b,
        way_c,
        way_d
    } way_e;

endpackage

`default_nettype wire

/* source/hit_miss.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module hit_miss (
    input  cache_types::tag_entry_t   entry_a,
    input  cache_types::tag_entry_t   entry_b,
    input  cache_types::tag_entry_t   entry_c,
    input  cache_types::tag_entry_t   entry_d,
    input  logic                      valid_a,
    input  logic                      valid_b,
    input  logic                      valid_c,
    input  logic                      valid_d,
    input  logic [`CACHE_TAG_W-1:0]   curr_tag,
    input  cache_types::way_e         way_replace,
    output cache_types::hit_miss_e    result,
    output cache_types::way_e         way_visit
);

    // Match vector, [A][B][C][D] on [3:0]
    logic [3:0] match;
    logic       victim_dirty;

    // Invalid ways never match
    assign match[3] = valid_a && (entry_a.tag == curr_tag);
    assign match[2] = valid_b && (entry_b.tag == curr_tag);
    assign match[1] = valid_c && (entry_c.tag == curr_tag);
    assign match[0] = valid_d && (entry_d.tag == curr_tag);

    // Dirty only counts on a valid victim
    always_comb begin
        case (way_replace)
            cache_types::way_a: victim_dirty = valid_a && entry_a.dirty;
            cache_types::way_b: victim_dirty = valid_b && entry_b.dirty;
            cache_types::way_c: victim_dirty = valid_c && entry_c.dirty;
            default:            victim_dirty = valid_d && entry_d.dirty;
        endcase
    end

    always_comb begin
        result    = cache_types::hit;
        way_visit = way_replace;
        // Tags are unique within a set, so at most one bit is set
        if (match[3]) begin
            way_visit = cache_types::way_a;
        end else if (match[2]) begin
            way_visit = cache_types::way_b;
        end else if (match[1]) begin
            way_visit = cache_types::way_c;
        end else if (match[0]) begin
            way_visit = cache_types::way_d;
        end else if (victim_dirty) begin
            // Victim has to go out first
            result = cache_types::dirty_miss;
        end else begin
            result = cache_types::clean_miss;
        end
    end

endmodule

`default_nettype wire

/* source/plru_tree.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module plru_tree (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`CACHE_IDX_W-1:0]  set_index,
    input  logic                     plru_update,
    input  cache_types::way_e        way_visit,
    output cache_types::way_e        way_replace
);

    // Bit 2 root, bit 1 picks A/B, bit 0 picks C/D
    logic [2:0] tree [`CACHE_SETS];
    logic [2:0] cur;
    logic [2:0] next;

    assign cur = tree[set_index];

    // Follow the bits down to the victim
    always_comb begin
        if (!cur[2]) begin
            way_replace = cur[1] ? cache_types::way_b : cache_types::way_a;
        end else begin
            way_replace = cur[0] ? cache_types::way_d : cache_types::way_c;
        end
    end

    // Point away from the visited way, other pair bit untouched
    always_comb begin
        next = cur;
        case (way_visit)
            cache_types::way_a: next[2:1] = 2'b11;
            cache_types::way_b: next[2:1] = 2'b10;
            cache_types::way_c: {next[2], next[0]} = 2'b01;
            default:            {next[2], next[0]} = 2'b00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (plru_update) begin
            tree[set_index] <= next;
        end
    end

endmodule

`default_nettype wire

/* tb/cache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cache_defines.svh"

module cache_tb;

    localparam int resp_limit = 200;

    logic                        clk;
    logic                        rst_n;
    logic                        cpu_read;
    logic                        cpu_write;
    cache_types::cache_addr_u    cpu_addr;
    logic [`CACHE_WORD_W-1:0]    cpu_wdata;
    logic [`CACHE_WORD_W/8-1:0]  cpu_byte_en;
    logic                        cpu_resp;
    logic [`CACHE_WORD_W-1:0]    cpu_rdata;
    logic                        mem_read;
    logic                        mem_write;
    logic [`CACHE_ADDR_W-1:0]    mem_addr;
    logic [`CACHE_LINE_W-1:0]    mem_wdata;
    logic [`CACHE_LINE_W-1:0]    mem_rdata;
    logic                        mem_resp;

    // Memory image, 8 tags by 8 sets
    logic [`CACHE_LINE_W-1:0]    mem_array [64];
    int                          mem_reads;
    int                          mem_writes;
    // 1 for write-back, 0 for refill, in arrival order
    logic                        kind_q [$];
    cache_types::cache_addr_u    wb_addr_q [$];
    logic [`CACHE_LINE_W-1:0]    wb_line_q [$];

    // Reference model state
    logic [`CACHE_LINE_W-1:0]    ref_mem [64];
    logic                        ref_valid [`CACHE_SETS][`CACHE_WAYS];
    logic                        ref_dirty [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_TAG_W-1:0]     ref_tag [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_LINE_W-1:0]    ref_line [`CACHE_SETS][`CACHE_WAYS];
    logic [2:0]                  ref_plru [`CACHE_SETS];

    int   errors;
    int   test_errors;
    int   tests_run;
    int   tests_failed;
    int   seed;
    logic timed_out;

    cache i_cache (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_read    (cpu_read),
        .cpu_write   (cpu_write),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_byte_en (cpu_byte_en),
        .cpu_resp    (cpu_resp),
        .cpu_rdata   (cpu_rdata),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Line slot from tag[2:0] and index[2:0]
    function automatic int slot_of(input logic [`CACHE_ADDR_W-1:0] a);
        return {a[11:9], a[7:5]};
    endfunction

    // Fill value mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] word_addr);
        return (word_addr * 32'h0100_0193) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic cache_types::cache_addr_u make_addr(input int tag, input int set,
                                                           input int word);
        cache_types::cache_addr_u a;
        a.raw = '0;
        a.f.tag = tag;
        a.f.index = set;
        a.f.word = word;
        return a;
    endfunction

    // Root 0 goes to A/B, then the pair bit
    function automatic int victim_of(input logic [2:0] p);
        if (!p[2]) begin
            return p[1] ? 1 : 0;
        end
        return p[0] ? 3 : 2;
    endfunction

    // Point root and pair bit away from the visited way
    function automatic logic [2:0] touch(input logic [2:0] p, input int way);
        case (way)
            0:       return {1'b1, 1'b1, p[0]};
            1:       return {1'b1, 1'b0, p[0]};
            2:       return {1'b0, p[1], 1'b1};
            default: return {1'b0, p[1], 1'b0};
        endcase
    endfunction

    task automatic init_memory();
        logic [31:0] base;
        for (int s = 0; s < 64; s++) begin
            base = ((s >> 3) << 9) | ((s & 7) << 5);
            for (int w = 0; w < 8; w++) begin
                mem_array[s][w * 32 +: 32] = fill_word(base + w * 4);
            end
            ref_mem[s] = mem_array[s];
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            ref_plru[s] = 3'b000;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
    endtask

    // Memory model, answers 3 cycles after it sees a request
    initial begin : memory_model
        cache_types::cache_addr_u req_addr;
        logic                     req_write;
        logic [`CACHE_LINE_W-1:0] req_data;
        forever begin
            @(posedge clk);
            #2;
            if (rst_n && (mem_read || mem_write)) begin
                req_addr.raw = mem_addr;
                req_write = mem_write;
                req_data = mem_wdata;
                if (req_addr.raw[31:12] != 0 || req_addr.raw[8] || req_addr.raw[4:0] != 0) begin
                    $display("Memory model got an address it does not hold: %h", req_addr.raw);
                    errors++;
                end
                kind_q.push_back(req_write);
                if (req_write) begin
                    mem_writes++;
                    wb_addr_q.push_back(req_addr);
                    wb_line_q.push_back(req_data);
                end else begin
                    mem_reads++;
                end
                repeat (3) @(posedge clk);
                #1;
                mem_rdata = mem_array[slot_of(req_addr.raw)];
                if (req_write) begin
                    mem_array[slot_of(req_addr.raw)] = req_data;
                end
                mem_resp = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

    task automatic check_word(input string what, input logic [`CACHE_WORD_W-1:0] got,
                              input logic [`CACHE_WORD_W-1:0] exp);
        if (!timed_out && got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_line(input string what, input logic [`CACHE_LINE_W-1:0] got,
                              input logic [`CACHE_LINE_W-1:0] exp);
        if (!timed_out && got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_addr(input string what, input cache_types::cache_addr_u got,
                              input cache_types::cache_addr_u exp);
        if (!timed_out && got.raw !== exp.raw) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got.raw, exp.raw);
            errors++;
            test_errors++;
        end
    endtask

    // Expected outcome of one access, state updated in place
    task automatic ref_access(input logic is_write, input cache_types::cache_addr_u a,
                              input logic [31:0] data, input logic [3:0] be,
                              output logic [31:0] rdata, output logic miss, output logic wb,
                              output cache_types::cache_addr_u wb_addr,
                              output logic [`CACHE_LINE_W-1:0] wb_line);
        int                       s;
        int                       hw;
        cache_types::cache_addr_u fill_addr;
        s = a.f.index;
        hw = -1;
        miss = 1'b0;
        wb = 1'b0;
        wb_addr.raw = '0;
        wb_line = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == a.f.tag) begin
                hw = w;
            end
        end
        if (hw < 0) begin
            miss = 1'b1;
            hw = victim_of(ref_plru[s]);
            if (ref_valid[s][hw] && ref_dirty[s][hw]) begin
                wb = 1'b1;
                wb_addr.f.tag = ref_tag[s][hw];
                wb_addr.f.index = s;
                wb_line = ref_line[s][hw];
                ref_mem[slot_of(wb_addr.raw)] = wb_line;
            end
            fill_addr = make_addr(a.f.tag, s, 0);
            ref_line[s][hw] = ref_mem[slot_of(fill_addr.raw)];
            ref_tag[s][hw] = a.f.tag;
            ref_valid[s][hw] = 1'b1;
            ref_dirty[s][hw] = 1'b0;
        end
        rdata = ref_line[s][hw][a.f.word * 32 +: 32];
        if (is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_line[s][hw][a.f.word * 32 + b * 8 +: 8] = data[b * 8 +: 8];
                end
            end
            ref_dirty[s][hw] = 1'b1;
        end
        ref_plru[s] = touch(ref_plru[s], hw);
    endtask

    // Hold the request until cpu_resp, sampled mid-cycle
    task automatic cpu_access(input logic is_write, input cache_types::cache_addr_u a,
                              input logic [31:0] data, input logic [3:0] be,
                              output logic [31:0] rdata, output int cycles);
        logic done;
        done = 1'b0;
        cycles = 0;
        rdata = '0;
        if (timed_out) begin
            return;
        end
        cpu_read = !is_write;
        cpu_write = is_write;
        cpu_addr = a;
        cpu_wdata = data;
        cpu_byte_en = be;
        while (!done && cycles < resp_limit) begin
            @(posedge clk);
            cycles++;
            #3;
            if (cpu_resp) begin
                rdata = cpu_rdata;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("Timeout: no cpu_resp within %0d cycles for address %h", resp_limit, a.raw);
            timed_out = 1'b1;
        end
        @(posedge clk);
        #1;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
    endtask

    // One access against the reference, with traffic checks
    task automatic run_access(input logic is_write, input int tag, input int set, input int word,
                              input logic [31:0] data, input logic [3:0] be,
                              output logic was_miss);
        cache_types::cache_addr_u a;
        cache_types::cache_addr_u exp_wb_addr;
        logic [`CACHE_LINE_W-1:0] exp_wb_line;
        logic [31:0]              exp_rdata;
        logic [31:0]              got_rdata;
        logic                     exp_miss;
        logic                     exp_wb;
        int                       reads0;
        int                       writes0;
        int                       kinds0;
        int                       cycles;
        a = make_addr(tag, set, word);
        ref_access(is_write, a, data, be, exp_rdata, exp_miss, exp_wb, exp_wb_addr, exp_wb_line);
        reads0 = mem_reads;
        writes0 = mem_writes;
        kinds0 = kind_q.size();
        cpu_access(is_write, a, data, be, got_rdata, cycles);
        was_miss = (mem_reads != reads0);
        if (!is_write) begin
            check_word("read data", got_rdata, exp_rdata);
        end
        check_word("memory reads", mem_reads - reads0, {31'b0, exp_miss});
        check_word("memory writes", mem_writes - writes0, {31'b0, exp_wb});
        // Hits answer one cycle after the request
        if (!exp_miss) begin
            check_word("hit latency", cycles, 1);
        end
        if (exp_wb && mem_writes != writes0) begin
            check_addr("write-back address", wb_addr_q[$], exp_wb_addr);
            check_line("write-back line", wb_line_q[$], exp_wb_line);
            check_word("write-back ahead of refill", {31'b0, kind_q[kinds0]}, 1);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (timed_out) begin
            $display("Test %s: aborted", name);
            tests_failed++;
        end else if (test_errors == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_reset_state();
        logic miss;
        check_word("cpu_resp after reset", {31'b0, cpu_resp}, 0);
        check_word("mem_read after reset", {31'b0, mem_read}, 0);
        check_word("mem_write after reset", {31'b0, mem_write}, 0);
        run_access(1'b0, 7, 0, 0, '0, 4'h0, miss);
        check_word("first read misses", {31'b0, miss}, 1);
        run_access(1'b0, 2, 7, 5, '0, 4'h0, miss);
        check_word("read to another set misses", {31'b0, miss}, 1);
        finish_test("reset state");
    endtask

    task automatic test_read_miss_hit();
        logic miss;
        run_access(1'b0, 1, 1, 3, '0, 4'h0, miss);
        check_word("cold read misses", {31'b0, miss}, 1);
        run_access(1'b0, 1, 1, 3, '0, 4'h0, miss);
        check_word("repeat read hits", {31'b0, miss}, 0);
        finish_test("read miss then hit");
    endtask

    task automatic test_partial_write();
        logic miss;
        // Bytes 0 and 2 only
        run_access(1'b1, 1, 1, 3, 32'hdead_beef, 4'b0101, miss);
        check_word("write hit stays local", {31'b0, miss}, 0);
        run_access(1'b0, 1, 1, 3, '0, 4'h0, miss);
        finish_test("partial write hit");
    endtask

    task automatic test_plru_evict();
        logic miss;
        int   victim;
        int   evicted;
        for (int t = 0; t < 4; t++) begin
            run_access(1'b0, t, 2, 1, '0, 4'h0, miss);
        end
        victim = victim_of(ref_plru[2]);
        evicted = ref_tag[2][victim];
        run_access(1'b0, 4, 2, 1, '0, 4'h0, miss);
        check_word("fifth tag misses", {31'b0, miss}, 1);
        run_access(1'b0, evicted, 2, 1, '0, 4'h0, miss);
        check_word("evicted tag misses again", {31'b0, miss}, 1);
        finish_test("plru eviction");
    endtask

    task automatic test_dirty_victim();
        logic miss;
        int   wb0;
        wb0 = wb_addr_q.size();
        run_access(1'b1, 0, 3, 2, 32'h1234_5678, 4'hf, miss);
        // Four more tags push the dirty line out
        for (int t = 1; t < 5; t++) begin
            run_access(1'b0, t, 3, 6, '0, 4'h0, miss);
        end
        check_word("write-back count", wb_addr_q.size() - wb0, 1);
        finish_test("dirty victim");
    endtask

    task automatic test_random_mix();
        logic        miss;
        logic [31:0] r;
        logic [31:0] data;
        logic [3:0]  be;
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            data = $random(seed);
            be = r[27:24];
            if (be == 4'h0) begin
                be = 4'hf;
            end
            run_access(r[0], r[23:16] % 6, 4 + (r[15:8] % 3), r[3:1], data, be, miss);
        end
        finish_test("random mix");
    endtask

    initial begin
        seed = 73;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        mem_reads = 0;
        mem_writes = 0;
        timed_out = 1'b0;
        rst_n = 1'b0;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_byte_en = '0;
        mem_rdata = '0;
        mem_resp = 1'b0;
        init_memory();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_read_miss_hit();
        test_partial_write();
        test_plru_evict();
        test_dirty_victim();
        test_random_mix();

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
